/* logic/ecc_defines.svh */
/*
 * Bank geometry and word widths for the ECC-protected SRAM bank
 * Depth, address width, data width and SECDED codeword width
 */

`ifndef ECC_DEFINES_SVH
`define ECC_DEFINES_SVH

// Number of codewords held in the bank
`define ECC_BANK_WORDS 256

// Address width, log2 of the bank depth
`define ECC_ADDR_W 8

// Payload width seen by the interconnect
`define ECC_DATA_W 32

// 32 data bits, 6 Hamming check bits and one overall parity bit
`define ECC_CODE_W 39

`endif

/* logic/ecc_pkg.sv */
/*
 * Shared types for the ECC bank
 * Interconnect request and response, bank port request,
 * fault injection, error flags and scrubber states
 */

`include "ecc_defines.svh"

package ecc_pkg;

  typedef struct packed {
    logic uncorrectable;
    logic correctable;
  } ecc_err_t;

  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`ECC_ADDR_W-1:0] addr;
    logic [`ECC_DATA_W-1:0] wdata;
  } intc_req_t;

  typedef struct packed {
    logic                   rvalid;
    logic [`ECC_DATA_W-1:0] rdata;
    ecc_err_t               err;
  } intc_rsp_t;

  // Bank port carries full codewords
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`ECC_ADDR_W-1:0] addr;
    logic [`ECC_CODE_W-1:0] wdata;
  } bank_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`ECC_ADDR_W-1:0] addr;
    logic [`ECC_CODE_W-1:0] mask;
  } fault_t;

  typedef enum logic [1:0] {
    Idle,
    Read,
    Check
  } scrub_state_e;

endpackage

/* logic/secded_39_32_enc.sv */
/*
 * SECDED (39,32) encoder, extended Hamming code
 * Bit index equals code position, position 0 holds overall parity
 */

`timescale 1ns/10ps

`include "ecc_defines.svh"

module secded_39_32_enc (
  input  logic [`ECC_DATA_W-1:0] data_i,
  output logic [`ECC_CODE_W-1:0] code_o
);

  always_comb begin : proc_encode
    logic [`ECC_CODE_W-1:0] code;
    int                     d;
    code = '0;
    d    = 0;

    // Data fills every position that is not a power of two
    for (int pos = 1; pos < `ECC_CODE_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        code[pos] = data_i[d];
        d++;
      end
    end

    // Check bit k covers all positions with bit k of the index set
    for (int k = 0; k < 6; k++) begin
      for (int pos = 1; pos < `ECC_CODE_W; pos++) begin
        if (pos[k] && (pos != (1 << k))) begin
          code[1 << k] = code[1 << k] ^ code[pos];
        end
      end
    end

    // Overall parity makes the full word even
    code[0] = ^code[`ECC_CODE_W-1:1];
    code_o  = code;
  end

endmodule

/* logic/secded_39_32_dec.sv */
/*
 * SECDED (39,32) decoder
 * Syndrome and overall parity check, single-bit correction,
 * correctable and uncorrectable error flags
 */

`timescale 1ns/10ps

`include "ecc_defines.svh"

module secded_39_32_dec (
  input  logic [`ECC_CODE_W-1:0] code_i,
  output logic [`ECC_DATA_W-1:0] data_o,
  output ecc_pkg::ecc_err_t      err_o
);

  always_comb begin : proc_decode
    logic [5:0]             syn;
    logic                   par;
    logic [`ECC_CODE_W-1:0] fixed;
    int                     d;
    syn    = '0;
    d      = 0;
    data_o = '0;

    // Syndrome is the XOR of the positions of all flipped bits
    for (int k = 0; k < 6; k++) begin
      for (int pos = 1; pos < `ECC_CODE_W; pos++) begin
        if (pos[k]) begin
          syn[k] = syn[k] ^ code_i[pos];
        end
      end
    end
    par   = ^code_i;
    fixed = code_i;

    // Odd parity names the bad position, a zero syndrome means the parity bit
    err_o.correctable   = par && (syn < `ECC_CODE_W);
    // Double error, or a syndrome past the last position
    err_o.uncorrectable = (!par && (syn != 6'd0)) || (syn >= `ECC_CODE_W);

    if (err_o.correctable) begin
      fixed[syn] = ~fixed[syn];
    end

    for (int pos = 1; pos < `ECC_CODE_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        data_o[d] = fixed[pos];
        d++;
      end
    end
  end

  always_comb begin : proc_err_check
    assert (!(err_o.correctable && err_o.uncorrectable))
      else $error("decoder flagged correctable and uncorrectable together");
  end

endmodule

/* logic/sram_bank.sv */
/*
 * Single-port SRAM bank of 39-bit codewords
 * Registered read data, write port and fault-injection XOR port
 */

`timescale 1ns/10ps

`include "ecc_defines.svh"

module sram_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  ecc_pkg::bank_req_t     req_i,
  input  ecc_pkg::fault_t        fault_i,
  output logic [`ECC_CODE_W-1:0] rdata_o
);

  logic [`ECC_CODE_W-1:0] mem [`ECC_BANK_WORDS];
  logic                   wr_en;
  logic                   flip_en;

  assign wr_en   = req_i.req && req_i.we;
  // A write to the same word overrides the injected flip
  assign flip_en = fault_i.valid && !(wr_en && (req_i.addr == fault_i.addr));

  always_ff @(posedge clk_i) begin : proc_array
    if (wr_en) begin
      mem[req_i.addr] <= req_i.wdata;
    end
    if (flip_en) begin
      mem[fault_i.addr] <= mem[fault_i.addr] ^ fault_i.mask;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rdata
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i.req && !req_i.we) begin
      rdata_o <= mem[req_i.addr];
    end
  end

endmodule

/* logic/ecc_scrubber.sv */
/*
 * Background scrubber for the ECC bank
 * Idle, Read, Check FSM, bank port mux with interconnect priority,
 * working address and count of corrected words
 */

`timescale 1ns/10ps

`include "ecc_defines.svh"

module ecc_scrubber (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   scrub_trigger_i,
  input  ecc_pkg::bank_req_t     intc_req_i,
  output ecc_pkg::bank_req_t     bank_req_o,
  input  logic [`ECC_CODE_W-1:0] bank_rdata_i,
  output logic [31:0]            bit_corrections_o,
  output logic                   scrub_busy_o
);

  import ecc_pkg::*;

  scrub_state_e           state_d, state_q;
  logic [`ECC_ADDR_W-1:0] working_addr_d, working_addr_q;
  logic [31:0]            corr_cnt_q;
  logic                   corr_en;

  logic                   scrub_req;
  logic                   scrub_we;
  logic [`ECC_DATA_W-1:0] scrub_data;
  logic [`ECC_CODE_W-1:0] scrub_wdata;
  ecc_err_t               scrub_err;

  // Correction path, re-encode the decoded word
  secded_39_32_dec u_scrub_dec (
    .code_i (bank_rdata_i),
    .data_o (scrub_data),
    .err_o  (scrub_err)
  );

  secded_39_32_enc u_scrub_enc (
    .data_i (scrub_data),
    .code_o (scrub_wdata)
  );

  // Interconnect always wins the port
  always_comb begin : proc_port_mux
    bank_req_o = intc_req_i;
    if (!intc_req_i.req) begin
      bank_req_o.req   = scrub_req;
      bank_req_o.we    = scrub_we;
      bank_req_o.addr  = working_addr_q;
      bank_req_o.wdata = scrub_wdata;
    end
  end

  always_comb begin : proc_fsm
    state_d        = state_q;
    working_addr_d = working_addr_q;
    scrub_req      = 1'b0;
    scrub_we       = 1'b0;
    corr_en        = 1'b0;

    case (state_q)
      Idle: begin
        if (scrub_trigger_i) begin
          state_d = Read;
        end
      end
      Read: begin
        scrub_req = 1'b1;
        if (!intc_req_i.req) begin
          state_d = Check;
        end
      end
      Check: begin
        if (scrub_err.correctable) begin
          scrub_req = 1'b1;
          scrub_we  = 1'b1;
          if (intc_req_i.req) begin
            // Pre-empted, read the word again
            state_d = Read;
          end else begin
            state_d        = Idle;
            working_addr_d = working_addr_q + 1'b1;
            corr_en        = 1'b1;
          end
        end else begin
          // Clean or beyond repair, move on
          state_d        = Idle;
          working_addr_d = working_addr_q + 1'b1;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_regs
    if (!rst_ni) begin
      state_q        <= Idle;
      working_addr_q <= '0;
      corr_cnt_q     <= '0;
    end else begin
      state_q        <= state_d;
      working_addr_q <= working_addr_d;
      if (corr_en) begin
        corr_cnt_q <= corr_cnt_q + 32'd1;
      end
    end
  end

  assign bit_corrections_o = corr_cnt_q;
  assign scrub_busy_o      = (state_q != Idle);

  // A scrub access that meets an interconnect request is retried from Read
  a_intc_priority: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (scrub_req && intc_req_i.req) |=>
      ((state_q == Read) && (working_addr_q == $past(working_addr_q))))
    else $error("pre-empted scrub access was not retried");

  // Each count step matches a write-back from Check that reached the bank
  a_count_in_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (corr_cnt_q != $past(corr_cnt_q)) |->
      (($past(state_q) == Check) &&
       $past(bank_req_o.req && bank_req_o.we && !intc_req_i.req) &&
       (corr_cnt_q == $past(corr_cnt_q) + 32'd1)))
    else $error("correction count changed outside a Check write-back");

endmodule

/* logic/ecc_bank_top.sv */
/*
 * ECC-protected SRAM bank
 * Interconnect encode and decode paths, scrubber, storage array
 */

`timescale 1ns/10ps

`include "ecc_defines.svh"

module ecc_bank_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  ecc_pkg::intc_req_t intc_req_i,
  input  ecc_pkg::fault_t    fault_i,
  input  logic               scrub_trigger_i,
  output ecc_pkg::intc_rsp_t intc_rsp_o,
  output logic [31:0]        bit_corrections_o,
  output logic               scrub_busy_o
);

  import ecc_pkg::*;

  logic [`ECC_CODE_W-1:0] intc_code;
  logic [`ECC_CODE_W-1:0] bank_rdata;
  bank_req_t              intc_bank_req;
  bank_req_t              bank_req;
  logic                   rvalid_q;

  secded_39_32_enc u_intc_enc (
    .data_i (intc_req_i.wdata),
    .code_o (intc_code)
  );

  assign intc_bank_req = '{
    req:   intc_req_i.req,
    we:    intc_req_i.we,
    addr:  intc_req_i.addr,
    wdata: intc_code
  };

  ecc_scrubber u_ecc_scrubber (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .scrub_trigger_i   (scrub_trigger_i),
    .intc_req_i        (intc_bank_req),
    .bank_req_o        (bank_req),
    .bank_rdata_i      (bank_rdata),
    .bit_corrections_o (bit_corrections_o),
    .scrub_busy_o      (scrub_busy_o)
  );

  sram_bank u_sram_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (bank_req),
    .fault_i (fault_i),
    .rdata_o (bank_rdata)
  );

  // Read data arrives one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rvalid
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= intc_req_i.req && !intc_req_i.we;
    end
  end

  assign intc_rsp_o.rvalid = rvalid_q;

  secded_39_32_dec u_intc_dec (
    .code_i (bank_rdata),
    .data_o (intc_rsp_o.rdata),
    .err_o  (intc_rsp_o.err)
  );

endmodule

/* bench/tb_ecc_bank.sv */
/*
 * Testbench for the ECC-protected SRAM bank
 * Reference model of data words, injected flips and scrub progress,
 * directed and random stimulus, concurrent checks and watchdog
 */

`timescale 1ns/10ps

`include "ecc_defines.svh"

module tb_ecc_bank;

  import ecc_pkg::*;

  localparam int RAND_OPS    = 120;
  localparam int STIM_CYCLES = `ECC_BANK_WORDS + RAND_OPS + 4 * 260 + 100;
  localparam int WATCHDOG_NS = STIM_CYCLES * 40 + 4000;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  intc_req_t   intc_req;
  fault_t      fault;
  logic        scrub_trigger;
  intc_rsp_t   intc_rsp;
  logic [31:0] bit_corrections;
  logic        scrub_busy;

  // Reference model
  logic [`ECC_DATA_W-1:0] shadow [`ECC_BANK_WORDS];
  logic [`ECC_CODE_W-1:0] flip_mask [`ECC_BANK_WORDS];
  logic [`ECC_ADDR_W-1:0] model_addr = '0;
  logic [31:0]            model_corr = '0;

  // Expected response of the read driven now, and of the one answered now
  logic                   pend_valid = 1'b0;
  logic [`ECC_DATA_W-1:0] pend_data  = '0;
  ecc_err_t               pend_err   = '0;
  logic                   chk_valid  = 1'b0;
  logic [`ECC_DATA_W-1:0] chk_data   = '0;
  ecc_err_t               chk_err    = '0;
  logic                   hold_busy  = 1'b0;

  int          errors   = 0;
  int          timeouts = 0;

  ecc_bank_top u_ecc_bank_top (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .intc_req_i        (intc_req),
    .fault_i           (fault),
    .scrub_trigger_i   (scrub_trigger),
    .intc_rsp_o        (intc_rsp),
    .bit_corrections_o (bit_corrections),
    .scrub_busy_o      (scrub_busy)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    chk_valid <= pend_valid;
    chk_data  <= pend_data;
    chk_err   <= pend_err;
  end

  // End of a scrub step, a single flip at the working address gets repaired
  always @(negedge scrub_busy) begin
    if (rst_ni === 1'b1) begin
      if ($countones(flip_mask[model_addr]) == 1) begin
        model_corr           = model_corr + 32'd1;
        flip_mask[model_addr] = '0;
      end
      model_addr = model_addr + 8'd1;
    end
  end

  function automatic void log_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
  endfunction

  function automatic ecc_err_t expected_err(logic [`ECC_CODE_W-1:0] mask);
    ecc_err_t e;
    e               = '0;
    e.correctable   = ($countones(mask) == 1);
    e.uncorrectable = ($countones(mask) == 2);
    return e;
  endfunction

  function automatic logic [`ECC_DATA_W-1:0] fill_word(logic [7:0] a);
    return {a, ~a, a ^ 8'h5a, a + 8'h33};
  endfunction

  function automatic logic [`ECC_CODE_W-1:0] one_hot(int pos);
    return {{(`ECC_CODE_W-1){1'b0}}, 1'b1} << pos;
  endfunction

  a_rvalid: assert property (@(posedge clk_i) intc_rsp.rvalid == chk_valid)
    else log_mismatch("intc_rsp_o.rvalid", $sampled(intc_rsp.rvalid), $sampled(chk_valid));

  a_rdata: assert property (@(posedge clk_i)
    (chk_valid && !chk_err.uncorrectable) |-> (intc_rsp.rdata == chk_data))
    else log_mismatch("intc_rsp_o.rdata", $sampled(intc_rsp.rdata), $sampled(chk_data));

  a_err: assert property (@(posedge clk_i) chk_valid |-> (intc_rsp.err == chk_err))
    else log_mismatch("intc_rsp_o.err", $sampled(intc_rsp.err), $sampled(chk_err));

  a_count: assert property (@(posedge clk_i) bit_corrections == model_corr)
    else log_mismatch("bit_corrections_o", $sampled(bit_corrections), $sampled(model_corr));

  a_busy_reset: assert property (@(posedge clk_i) !rst_ni |-> !scrub_busy)
    else log_mismatch("scrub_busy_o", $sampled(scrub_busy), 32'd0);

  a_busy_hold: assert property (@(posedge clk_i) hold_busy |-> scrub_busy)
    else log_mismatch("scrub_busy_o", $sampled(scrub_busy), 32'd1);

  // One clock edge, then inputs return to idle
  task automatic cycle();
    @(posedge clk_i);
    #2;
    intc_req      = '0;
    fault         = '0;
    scrub_trigger = 1'b0;
    pend_valid    = 1'b0;
  endtask

  task automatic write_word(logic [7:0] addr, logic [`ECC_DATA_W-1:0] data);
    intc_req        = '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    shadow[addr]    = data;
    flip_mask[addr] = '0;
    cycle();
  endtask

  task automatic read_word(logic [7:0] addr);
    intc_req   = '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    pend_valid = 1'b1;
    pend_data  = shadow[addr];
    pend_err   = expected_err(flip_mask[addr]);
    cycle();
  endtask

  task automatic inject(logic [7:0] addr, logic [`ECC_CODE_W-1:0] mask);
    fault           = '{valid: 1'b1, addr: addr, mask: mask};
    flip_mask[addr] = flip_mask[addr] ^ mask;
    cycle();
  endtask

  task automatic wait_scrub_done();
    int n;
    n = 0;
    while (scrub_busy && n < 20) begin
      cycle();
      n++;
    end
    if (scrub_busy) begin
      timeouts++;
      $display("scrub step still busy after %0d cycles at %0t", n, $time);
    end
  endtask

  task automatic scrub_step();
    scrub_trigger = 1'b1;
    cycle();
    wait_scrub_done();
  endtask

  task automatic finish_run();
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin
    #(WATCHDOG_NS);
    timeouts++;
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    finish_run();
  end

  initial begin
    logic [7:0] addr;
    int         pos;
    void'($urandom(38015));
    rst_ni        = 1'b0;
    intc_req      = '0;
    fault         = '0;
    scrub_trigger = 1'b0;
    foreach (flip_mask[i]) begin
      flip_mask[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Every word gets known data so scrub reads are always defined
    for (int a = 0; a < `ECC_BANK_WORDS; a++) begin
      write_word(a[7:0], fill_word(a[7:0]));
    end
    write_word(8'h10, 32'hcafe_f00d);
    read_word(8'h10);

    // Single flip seen on a read, away from the early scrub addresses
    addr = 8'h80 | 8'($urandom % 128);
    inject(addr, one_hot($urandom % 39));
    read_word(addr);

    // Scrub repairs a single flip
    addr = model_addr;
    inject(addr, one_hot($urandom % 39));
    scrub_step();
    read_word(addr);

    // Double flip stays uncorrectable through a scrub
    addr = model_addr;
    pos  = $urandom % 39;
    inject(addr, one_hot(pos) | one_hot((pos + 1 + $urandom % 38) % 39));
    read_word(addr);
    scrub_step();
    read_word(addr);

    // Scrub pending under back-to-back interconnect traffic
    inject(model_addr, one_hot($urandom % 39));
    scrub_trigger = 1'b1;
    cycle();
    hold_busy = 1'b1;
    repeat (RAND_OPS) begin
      addr = 8'($urandom);
      if ($urandom % 2) begin
        write_word(addr, $urandom);
      end else begin
        read_word(addr);
      end
    end
    hold_busy = 1'b0;
    wait_scrub_done();

    // Extra triggers while busy give one step only
    repeat (3) begin
      scrub_trigger = 1'b1;
      cycle();
    end
    wait_scrub_done();
    inject(model_addr, one_hot($urandom % 39));
    scrub_step();

    // Sweep to the last word, then wrap to word 0
    while (model_addr != 8'hff) begin
      scrub_step();
    end
    inject(8'hff, one_hot($urandom % 39));
    scrub_step();
    inject(8'h00, one_hot($urandom % 39));
    scrub_step();
    read_word(8'h00);
    cycle();
    cycle();
    finish_run();
  end

endmodule

/* filelist.f */
+incdir+logic
logic/ecc_pkg.sv
logic/secded_39_32_enc.sv
logic/secded_39_32_dec.sv
logic/sram_bank.sv
logic/ecc_scrubber.sv
logic/ecc_bank_top.sv
bench/tb_ecc_bank.sv

/* Makefile */
# Verilator build and run for the ECC bank testbench

VERILATOR ?= verilator
TOP       ?= tb_ecc_bank
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert -Wno-fatal -j $(JOBS)
PASS_MSG  ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
